/* dv/tb_cpu_backend.sv */
`timescale 1ns/10ps

module tb_cpu_backend
    import common_pkg::*;
    ();

typedef logic [DMEM_ADDR_W-1:0] widx_t; // data memory word index

localparam int RESET_CYCLES   = 4;
localparam int N_ALU          = 6;
localparam int N_PRELOAD      = 16;  // words touched by the memory tests
localparam int N_STORE_ROUNDS = 2;
localparam int N_CHAIN        = 8;
// cycles per test, plus slack
localparam int CYCLE_LIMIT    = RESET_CYCLES + 6 + N_ALU * 3 + 3 + N_PRELOAD
                              + N_STORE_ROUNDS * 8 * 3 + 14 * 2 + N_CHAIN + 1 + 50;

logic     clk_i;
logic     reset_i;
word_t    ex_pc_i;
word_t    ex_ir_i;
word_t    ex_result_i;
word_t    ex_store_data_i;
logic     ex_load_i;
logic     ex_store_i;
logic     ex_wb_valid_i;
ma_size_t ex_ma_size_i;
regaddr_t rs1_addr_i;
regaddr_t rs2_addr_i;
word_t    rs1_data_o;
word_t    rs2_data_o;
regaddr_t wb_addr_o;
word_t    wb_data_o;
logic     wb_valid_o;
logic     empty_o;

word_t    lfsr_state  = 32'h9064_9428;
word_t    pc_count    = 32'h0000_1000;
word_t    mem_model [DMEM_WORDS];       // expected memory contents
int       error_count = 0;
int       check_count = 0;
int       cycle_count = 0;

ma_size_t store_sizes [3] = '{MA_SIZE_B, MA_SIZE_H, MA_SIZE_W};
ma_size_t load_sizes  [4] = '{MA_SIZE_B, MA_SIZE_BU, MA_SIZE_H, MA_SIZE_HU};
ma_size_t chain_sizes [5] = '{MA_SIZE_W, MA_SIZE_B, MA_SIZE_HU, MA_SIZE_BU, MA_SIZE_H};

cpu_backend UUT (.*);

initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i; // 8 ns period
end

always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
        $display("timeout: tests still running after %0d cycles", cycle_count);
        $display("=== FAIL ===");
        $finish;
    end
end

// galois lfsr, one step per bit taken
function automatic word_t take_bits(int n);
    word_t bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        bits = {bits[30:0], lfsr_state[0]};
        if (lfsr_state[0])
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
        else
            lfsr_state = lfsr_state >> 1;
    end
    return bits;
endfunction

function automatic regaddr_t random_rd();
    word_t t;
    t = take_bits(5);
    if (t[4:0] == 5'd0)
        t = 32'd1; // keep clear of x0
    return t[4:0];
endfunction

function automatic widx_t random_idx();
    word_t t;
    widx_t idx;
    t = take_bits(4);
    idx = '0;
    idx[3:0] = t[3:0]; // stay inside the preloaded words
    return idx;
endfunction

function automatic word_t make_addr(widx_t idx, int align);
    word_t addr;
    addr = '0;
    addr[DMEM_ADDR_W+1:2] = idx;
    addr[1:0] = align[1:0];
    return addr;
endfunction

function automatic logic is_legal(ma_size_t size, int align);
    if (size == MA_SIZE_W)
        return align == 0;
    if (size == MA_SIZE_H || size == MA_SIZE_HU)
        return align < 3;
    return 1'b1;
endfunction

function automatic word_t next_pc();
    pc_count = pc_count + 32'd4;
    return pc_count;
endfunction

// merge the stored bytes into the model lane by lane
function automatic void store_model(word_t addr, word_t data, ma_size_t size);
    int    nbytes;
    int    lane;
    widx_t idx;
    idx = addr[DMEM_ADDR_W+1:2];
    if (size == MA_SIZE_W)
        nbytes = 4;
    else if (size == MA_SIZE_H || size == MA_SIZE_HU)
        nbytes = 2;
    else
        nbytes = 1;
    for (int k = 0; k < nbytes; k++) begin
        lane = int'(addr[1:0]) + k;
        mem_model[idx][lane*8 +: 8] = data[k*8 +: 8];
    end
endfunction

function automatic word_t load_expect(word_t addr, ma_size_t size);
    word_t       w;
    logic [7:0]  b;
    logic [15:0] h;
    int          a;
    a = int'(addr[1:0]);
    w = mem_model[addr[DMEM_ADDR_W+1:2]];
    b = w[a*8 +: 8];
    h = (a < 3) ? w[a*8 +: 16] : 16'h0;
    case (size)
    MA_SIZE_B:  return {{24{b[7]}}, b};
    MA_SIZE_BU: return {24'h0, b};
    MA_SIZE_H:  return {{16{h[15]}}, h};
    MA_SIZE_HU: return {16'h0, h};
    default:    return w;
    endcase
endfunction

task automatic check_word(input string name, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[FAIL] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_addr(input string name, input regaddr_t got, input regaddr_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[FAIL] %s got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_wb(input regaddr_t rd, input word_t exp);
    check_flag("wb_valid_o", wb_valid_o, 1'b1);
    check_addr("wb_addr_o", wb_addr_o, rd);
    check_word("wb_data_o", wb_data_o, exp);
endtask

// one instruction per call, driven at the rising edge
task automatic issue_instr(input word_t pc, input regaddr_t rd, input word_t result,
                           input word_t store_data, input logic load, input logic store,
                           input logic wb_valid, input ma_size_t size);
    logic [6:0] opcode;
    opcode = load ? 7'b0000011 : (store ? 7'b0100011 : 7'b0110011);
    @(posedge clk_i);
    ex_pc_i         <= pc;
    ex_ir_i         <= {17'd0, size, rd, opcode};
    ex_result_i     <= result;
    ex_store_data_i <= store_data;
    ex_load_i       <= load;
    ex_store_i      <= store;
    ex_wb_valid_i   <= wb_valid;
    ex_ma_size_i    <= size;
endtask

task automatic issue_bubble();
    issue_instr(NOP_PC, '0, '0, '0, 1'b0, 1'b0, NOP_WB_VALID, MA_SIZE_W);
endtask

task automatic issue_alu(input regaddr_t rd, input word_t result);
    issue_instr(next_pc(), rd, result, '0, 1'b0, 1'b0, 1'b1, MA_SIZE_W);
endtask

task automatic issue_store(input word_t addr, input word_t data, input ma_size_t size);
    issue_instr(next_pc(), '0, addr, data, 1'b0, 1'b1, 1'b0, size);
    store_model(addr, data, size);
endtask

task automatic issue_load(input word_t addr, input regaddr_t rd, input ma_size_t size);
    issue_instr(next_pc(), rd, addr, '0, 1'b1, 1'b0, 1'b1, size);
endtask

// call right after an issue task, still on the same edge
task automatic set_reads(input regaddr_t rs1, input regaddr_t rs2);
    rs1_addr_i <= rs1;
    rs2_addr_i <= rs2;
endtask

task automatic test_reset_and_bubbles();
    regaddr_t rd;
    word_t    result;
    rd = random_rd();
    result = take_bits(32) & 32'hFFFF_FFFC;
    @(negedge clk_i);
    check_flag("empty_o", empty_o, 1'b1);
    check_flag("wb_valid_o", wb_valid_o, 1'b0);
    issue_alu(rd, result);
    issue_bubble();
    @(negedge clk_i);
    check_flag("empty_o", empty_o, 1'b0);
    check_wb(rd, result);
    issue_bubble();
    @(negedge clk_i);
    check_flag("empty_o", empty_o, 1'b1);
    check_flag("wb_valid_o", wb_valid_o, 1'b0);
endtask

task automatic test_alu_writeback();
    regaddr_t rd;
    word_t    result;
    for (int i = 0; i < N_ALU; i++) begin
        rd = random_rd();
        result = take_bits(32) & 32'hFFFF_FFFC; // alignment comes from the low bits
        issue_alu(rd, result);
        issue_bubble();
        set_reads(rd, rd);
        @(negedge clk_i);
        check_wb(rd, result);
        check_word("rs1_data_o", rs1_data_o, result); // bypass
        check_word("rs2_data_o", rs2_data_o, result);
        issue_bubble();
        @(negedge clk_i);
        check_word("rs1_data_o", rs1_data_o, result);
        check_word("rs2_data_o", rs2_data_o, result);
    end
endtask

task automatic test_reg_zero();
    word_t result;
    result = take_bits(32) & 32'hFFFF_FFFC;
    issue_alu('0, result);
    issue_bubble();
    set_reads('0, '0);
    @(negedge clk_i);
    check_wb('0, result);
    check_word("rs1_data_o", rs1_data_o, '0);
    check_word("rs2_data_o", rs2_data_o, '0);
    issue_bubble();
    @(negedge clk_i);
    check_word("rs1_data_o", rs1_data_o, '0);
    check_word("rs2_data_o", rs2_data_o, '0);
endtask

task automatic test_store_word_load();
    widx_t    idx;
    regaddr_t rd;
    for (int w = 0; w < N_PRELOAD; w++) begin
        issue_store(make_addr(widx_t'(w), 0), take_bits(32), MA_SIZE_W);
    end
    for (int r = 0; r < N_STORE_ROUNDS; r++) begin
        for (int s = 0; s < 3; s++) begin
            for (int a = 0; a < 4; a++) begin
                if (is_legal(store_sizes[s], a)) begin
                    idx = random_idx();
                    rd = random_rd();
                    issue_store(make_addr(idx, a), take_bits(32), store_sizes[s]);
                    issue_load(make_addr(idx, 0), rd, MA_SIZE_W);
                    issue_bubble();
                    @(negedge clk_i);
                    check_wb(rd, mem_model[idx]);
                end
            end
        end
    end
endtask

task automatic test_subword_loads();
    word_t    addr;
    regaddr_t rd;
    for (int s = 0; s < 4; s++) begin
        for (int a = 0; a < 4; a++) begin
            if (is_legal(load_sizes[s], a)) begin
                addr = make_addr(random_idx(), a);
                rd = random_rd();
                issue_load(addr, rd, load_sizes[s]);
                issue_bubble();
                @(negedge clk_i);
                check_wb(rd, load_expect(addr, load_sizes[s]));
            end
        end
    end
endtask

task automatic test_load_chain();
    regaddr_t rds  [N_CHAIN];
    word_t    exps [N_CHAIN];
    word_t    addr;
    word_t    t;
    ma_size_t size;
    int       a;
    for (int i = 0; i < N_CHAIN; i++) begin
        size = chain_sizes[i % 5];
        t = take_bits(2);
        a = int'(t[1:0]);
        if (!is_legal(size, a))
            a = (size == MA_SIZE_W) ? 0 : 2;
        addr = make_addr(random_idx(), a);
        rds[i] = regaddr_t'(8 + i);
        exps[i] = load_expect(addr, size);
        issue_load(addr, rds[i], size);
        if (i > 0) begin
            set_reads(rds[i-1], '0);
            @(negedge clk_i);
            check_wb(rds[i-1], exps[i-1]);
            check_word("rs1_data_o", rs1_data_o, exps[i-1]);
        end
    end
    issue_bubble();
    set_reads(rds[N_CHAIN-1], rds[0]);
    @(negedge clk_i);
    check_wb(rds[N_CHAIN-1], exps[N_CHAIN-1]);
    check_word("rs1_data_o", rs1_data_o, exps[N_CHAIN-1]);
    check_word("rs2_data_o", rs2_data_o, exps[0]); // from storage
endtask

initial begin
    reset_i         = 1'b1;
    ex_pc_i         = 32'h0000_0FFC; // live instruction waits through reset
    ex_ir_i         = '0;
    ex_result_i     = '0;
    ex_store_data_i = '0;
    ex_load_i       = 1'b0;
    ex_store_i      = 1'b0;
    ex_wb_valid_i   = 1'b1;
    ex_ma_size_i    = MA_SIZE_W;
    rs1_addr_i      = '0;
    rs2_addr_i      = '0;

    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i       <= 1'b0;
    ex_pc_i       <= NOP_PC;
    ex_wb_valid_i <= NOP_WB_VALID;

    test_reset_and_bubbles();
    test_alu_writeback();
    test_reg_zero();
    test_store_word_load();
    test_subword_loads();
    test_load_chain();

    $display("summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0)
        $display("=== PASS ===");
    else
        $display("=== FAIL ===");
    $finish;
end

endmodule

/* rtl/common_pkg.sv */
package common_pkg;

    // basic data path types
    typedef logic [31:0] word_t;    // data or address word
    typedef logic [4:0]  regaddr_t; // register index x0..x31
    typedef logic [3:0]  byte_en_t; // one bit per byte lane

    // memory access size, encoded like the load/store funct3 field
    typedef enum logic [2:0] {
        MA_SIZE_B  = 3'b000,  // signed byte
        MA_SIZE_H  = 3'b001,  // signed half
        MA_SIZE_W  = 3'b010,  // full word
        MA_SIZE_BU = 3'b100,  // unsigned byte
        MA_SIZE_HU = 3'b101   // unsigned half
    } ma_size_t;

    // bubble markers
    localparam word_t NOP_PC       = 32'hFFFF_FFFF; // pc of an empty slot
    localparam logic  NOP_WB_VALID = 1'b0;          // bubbles never write back

    // data memory geometry
    localparam int DMEM_WORDS  = 256;
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS); // word address width

endpackage

/* rtl/cpu_backend.sv */
`timescale 1ns/10ps

module cpu_backend
    import common_pkg::*;
    (
        input  wire logic     clk_i,
        input  wire logic     reset_i,

        // from execute
        input  wire word_t    ex_pc_i,
        input  wire word_t    ex_ir_i,
        input  wire word_t    ex_result_i,
        input  wire word_t    ex_store_data_i,
        input  wire logic     ex_load_i,
        input  wire logic     ex_store_i,
        input  wire logic     ex_wb_valid_i,
        input  wire ma_size_t ex_ma_size_i,

        // operand reads
        input  wire regaddr_t rs1_addr_i,
        input  wire regaddr_t rs2_addr_i,
        output      word_t    rs1_data_o,
        output      word_t    rs2_data_o,

        // write back view
        output      regaddr_t wb_addr_o,
        output      word_t    wb_data_o,
        output      logic     wb_valid_o,
        output      logic     empty_o
    );

// data memory port
logic [DMEM_ADDR_W-1:0] dmem_addr;
logic                   dmem_wr_en;
byte_en_t               dmem_byte_en;
word_t                  dmem_wr_data;
word_t                  dmem_rd_data;

ma_wb_if ma_wb ();

cpu_ma u_ma (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .ex_pc_i         (ex_pc_i),
    .ex_ir_i         (ex_ir_i),
    .ex_result_i     (ex_result_i),
    .ex_store_data_i (ex_store_data_i),
    .ex_load_i       (ex_load_i),
    .ex_store_i      (ex_store_i),
    .ex_wb_valid_i   (ex_wb_valid_i),
    .ex_ma_size_i    (ex_ma_size_i),
    .dmem_addr_o     (dmem_addr),
    .dmem_wr_en_o    (dmem_wr_en),
    .dmem_byte_en_o  (dmem_byte_en),
    .dmem_wr_data_o  (dmem_wr_data),
    .wb              (ma_wb.ma)
);

cpu_dmem u_dmem (
    .clk_i     (clk_i),
    .addr_i    (dmem_addr),
    .wr_en_i   (dmem_wr_en),
    .byte_en_i (dmem_byte_en),
    .wr_data_i (dmem_wr_data),
    .rd_data_o (dmem_rd_data)
);

cpu_wb u_wb (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .dmem_read_data_i (dmem_rd_data),
    .wb               (ma_wb.wb),
    .wb_addr_o        (wb_addr_o),
    .wb_data_o        (wb_data_o),
    .wb_valid_o       (wb_valid_o),
    .empty_o          (empty_o)
);

// register file is written straight from the write back outputs
cpu_regfile u_regfile (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .wr_addr_i  (wb_addr_o),
    .wr_data_i  (wb_data_o),
    .wr_en_i    (wb_valid_o),
    .rs1_addr_i (rs1_addr_i),
    .rs2_addr_i (rs2_addr_i),
    .rs1_data_o (rs1_data_o),
    .rs2_data_o (rs2_data_o)
);

endmodule

/* rtl/cpu_dmem.sv */
`timescale 1ns/10ps

module cpu_dmem
    import common_pkg::*;
    (
        input  wire logic                   clk_i,

        input  wire logic [DMEM_ADDR_W-1:0] addr_i,    // word address
        input  wire logic                   wr_en_i,
        input  wire byte_en_t               byte_en_i,
        input  wire word_t                  wr_data_i,
        output      word_t                  rd_data_o  // valid one cycle after addr
    );

word_t mem [DMEM_WORDS];

// read sees the contents from before this edge's write
always_ff @(posedge clk_i) begin
    rd_data_o <= mem[addr_i];
end

// byte lane writes
always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (byte_en_i[lane]) begin
                mem[addr_i][lane*8 +: 8] <= wr_data_i[lane*8 +: 8];
            end
        end
    end
end

endmodule

/* rtl/cpu_ma.sv */
`timescale 1ns/10ps

module cpu_ma
    import common_pkg::*;
    (
        input  wire logic                   clk_i,
        input  wire logic                   reset_i,

        // executed instruction
        input  wire word_t                  ex_pc_i,
        input  wire word_t                  ex_ir_i,
        input  wire word_t                  ex_result_i,     // address or alu value
        input  wire word_t                  ex_store_data_i,
        input  wire logic                   ex_load_i,
        input  wire logic                   ex_store_i,
        input  wire logic                   ex_wb_valid_i,
        input  wire ma_size_t               ex_ma_size_i,

        // data memory port
        output      logic [DMEM_ADDR_W-1:0] dmem_addr_o,
        output      logic                   dmem_wr_en_o,
        output      byte_en_t               dmem_byte_en_o,
        output      word_t                  dmem_wr_data_o,

        // register into write back
        ma_wb_if.ma                         wb
    );

logic [1:0] align_w;    // byte offset inside the word
byte_en_t   size_mask_w;

assign align_w = ex_result_i[1:0];

// word address, byte offset dropped
assign dmem_addr_o = ex_result_i[DMEM_ADDR_W+1:2];

always_comb begin
    // lanes covered by the access before shifting
    unique case (ex_ma_size_i)
    MA_SIZE_B,
    MA_SIZE_BU: size_mask_w = 4'b0001;
    MA_SIZE_H,
    MA_SIZE_HU: size_mask_w = 4'b0011;
    MA_SIZE_W:  size_mask_w = 4'b1111;
    default:    size_mask_w = 4'b0000;
    endcase
end

// move the store data up into its byte lanes
assign dmem_wr_data_o = ex_store_data_i << {align_w, 3'b000};
assign dmem_byte_en_o = size_mask_w << align_w;
assign dmem_wr_en_o   = ex_store_i && !reset_i; // no writes while in reset

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        wb.pc       <= NOP_PC;
        wb.load     <= 1'b0;
        wb.wb_valid <= NOP_WB_VALID;
    end else begin
        wb.pc       <= ex_pc_i;
        wb.load     <= ex_load_i;
        wb.wb_valid <= ex_wb_valid_i;
    end
end

// payload follows the instruction every cycle
always_ff @(posedge clk_i) begin
    wb.ir           <= ex_ir_i;
    wb.ma_size      <= ex_ma_size_i;
    wb.ma_alignment <= align_w;
    wb.wb_data      <= ex_result_i;
end

// misaligned accesses are not trapped, so they must never show up
a_half_not_split: assert property (
    @(posedge clk_i) disable iff (reset_i)
    ((ex_load_i || ex_store_i) && (ex_ma_size_i inside {MA_SIZE_H, MA_SIZE_HU}))
        |-> (ex_result_i[1:0] != 2'b11)
) else $error("half access crosses a word boundary");

a_word_aligned: assert property (
    @(posedge clk_i) disable iff (reset_i)
    ((ex_load_i || ex_store_i) && (ex_ma_size_i == MA_SIZE_W))
        |-> (ex_result_i[1:0] == 2'b00)
) else $error("word access not aligned");

endmodule

/* rtl/cpu_regfile.sv */
`timescale 1ns/10ps

module cpu_regfile
    import common_pkg::*;
    (
        input  wire logic     clk_i,
        input  wire logic     reset_i,

        // write port from write back
        input  wire regaddr_t wr_addr_i,
        input  wire word_t    wr_data_i,
        input  wire logic     wr_en_i,

        // read ports
        input  wire regaddr_t rs1_addr_i,
        input  wire regaddr_t rs2_addr_i,
        output      word_t    rs1_data_o,
        output      word_t    rs2_data_o
    );

word_t regs [1:31]; // x0 has no storage

logic wr_live_w;    // a real write this cycle

assign wr_live_w = wr_en_i && (wr_addr_i != '0);

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
        end
    end else if (wr_live_w) begin
        regs[wr_addr_i] <= wr_data_i;
    end
end

// bypass the incoming write so a reader sees it in the same cycle
always_comb begin
    if (rs1_addr_i == '0)
        rs1_data_o = '0;
    else if (wr_live_w && (wr_addr_i == rs1_addr_i))
        rs1_data_o = wr_data_i;
    else
        rs1_data_o = regs[rs1_addr_i];

    if (rs2_addr_i == '0)
        rs2_data_o = '0;
    else if (wr_live_w && (wr_addr_i == rs2_addr_i))
        rs2_data_o = wr_data_i;
    else
        rs2_data_o = regs[rs2_addr_i];
end

endmodule

/* rtl/cpu_wb.sv */
`timescale 1ns/10ps

module cpu_wb
    import common_pkg::*;
    (
        input  wire logic  clk_i,
        input  wire logic  reset_i,

        input  wire word_t dmem_read_data_i, // load data from memory

        ma_wb_if.wb        wb,               // pipeline register

        // register file write port
        output      regaddr_t wb_addr_o,
        output      word_t    wb_data_o,
        output      logic     wb_valid_o,
        output      logic     empty_o        // no instruction in this stage
    );

word_t unaligned_w;
word_t aligned_w;

always_comb begin
    unaligned_w = wb.load ? dmem_read_data_i : wb.wb_data;

    // bring the addressed byte down to bit 0
    aligned_w = unaligned_w >> {wb.ma_alignment, 3'b000};

    unique case (wb.ma_size)
    MA_SIZE_B:  wb_data_o = {{24{aligned_w[7]}}, aligned_w[7:0]};
    MA_SIZE_H:  wb_data_o = {{16{aligned_w[15]}}, aligned_w[15:0]};
    MA_SIZE_BU: wb_data_o = {24'b0, aligned_w[7:0]};
    MA_SIZE_HU: wb_data_o = {16'b0, aligned_w[15:0]};
    default:    wb_data_o = aligned_w; // word
    endcase

    wb_addr_o  = wb.ir[11:7]; // rd field
    wb_valid_o = wb.wb_valid;

    if (reset_i) begin
        wb_addr_o  = '0;
        wb_data_o  = '0;
        wb_valid_o = NOP_WB_VALID;
    end

    empty_o = reset_i || (wb.pc == NOP_PC);
end

// a bubble must never reach the register file
a_bubble_no_write: assert property (
    @(posedge clk_i) disable iff (reset_i)
    wb.wb_valid |-> (wb.pc != NOP_PC)
) else $error("write back valid on a bubble");

endmodule

/* rtl/ma_wb_if.sv */
`timescale 1ns/10ps

// pipeline register between memory access and write back
interface ma_wb_if
    import common_pkg::*;
    ();

    word_t      pc;           // program counter
    word_t      ir;           // instruction word
    logic       load;         // load instruction
    ma_size_t   ma_size;      // access size
    logic [1:0] ma_alignment; // low address bits
    word_t      wb_data;      // alu result
    logic       wb_valid;     // write back enable

    // memory access stage drives the register
    modport ma (
        output pc, ir, load, ma_size, ma_alignment, wb_data, wb_valid
    );

    // write back stage only reads it
    modport wb (
        input pc, ir, load, ma_size, ma_alignment, wb_data, wb_valid
    );

endinterface

/* run_sim.sh */
#!/bin/sh
# compile and run the backend testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_cpu_backend \
    -f tb.f \
    -o sim_tb_cpu_backend

sim_out=$(./obj_dir/sim_tb_cpu_backend 2>&1)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx '=== PASS ==='; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tb.f */
rtl/common_pkg.sv
rtl/ma_wb_if.sv
rtl/cpu_ma.sv
rtl/cpu_dmem.sv
rtl/cpu_wb.sv
rtl/cpu_regfile.sv
rtl/cpu_backend.sv
dv/tb_cpu_backend.sv
